/* hdl/fir_params.svh */
// ****************************************
// widths, tap counts and pipeline depths of the symmetric fir filter
// include wherever a size or stage count is needed
// ****************************************
`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// sample and internal arithmetic width
`define FIR_DATA_W 18

// taps and unique coefficients after the symmetry fold
`define FIR_NUM_TAPS 29
`define FIR_NUM_UNIQ 15

// adder tree, padded to a power of two
`define FIR_TREE_INPUTS 16
`define FIR_TREE_LEVELS 4

// product normalization, arithmetic shift right
`define FIR_SCALE 17

// register stages per tap and end to end
`define FIR_TAP_STAGES 2
`define FIR_LATENCY 7

`endif

/* hdl/fir_pkg.sv */
// ****************************************
// shared types and coefficient table of the fir filter
// referenced by scoped names from the rtl and the testbench
// ****************************************
`default_nettype none

`include "fir_params.svh"

package fir_pkg;

	// one signed sample, also the width of every internal sum
	typedef logic signed [`FIR_DATA_W-1:0] fir_sample_t;

	// mirrored tap pair, far is zero for the center tap
	typedef struct packed {
		fir_sample_t near;
		fir_sample_t far;
	} fir_pair_t;

	// scaled product out of one tap
	typedef logic signed [`FIR_DATA_W-1:0] fir_product_t;

	// ****************************************
	// coefficients for pairs 0 to 14
	// ****************************************
	localparam fir_sample_t FIR_COEFFS [`FIR_NUM_UNIQ] = '{
		18'sd88,
		18'sd0,
		-18'sd97,
		-18'sd197,
		-18'sd294,
		-18'sd380,
		-18'sd447,
		-18'sd490,
		-18'sd504,
		-18'sd481,
		-18'sd420,
		-18'sd319,
		-18'sd178,
		18'sd0,
		18'sd212
	};

endpackage

`default_nettype wire

/* hdl/tap_delay_line.sv */
// ****************************************
// sample shift register of the fir filter
// folds the 29 taps into 15 mirrored pairs and registers the input valid
// ****************************************
`timescale 1ns/1ps
`default_nettype none

`include "fir_params.svh"

module tap_delay_line (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_clk_ena,
	input  logic                  i_valid,
	input  fir_pkg::fir_sample_t  i_data,
	output fir_pkg::fir_pair_t    o_pairs [`FIR_NUM_UNIQ],
	output logic                  o_valid
);

	// the middle tap has no mirror partner
	localparam int CENTER = (`FIR_NUM_TAPS - 1) / 2;

	fir_pkg::fir_sample_t taps_q [`FIR_NUM_TAPS];
	logic                 valid_q;

	// ****************************************
	// shift chain
	// ****************************************
	// data shifts on every enabled edge, valid or not
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
				taps_q[k] <= '0;
			end
			valid_q <= 1'b0;
		end else if (i_clk_ena) begin
			taps_q[0] <= i_data;
			for (int k = 1; k < `FIR_NUM_TAPS; k++) begin
				taps_q[k] <= taps_q[k-1];
			end
			valid_q <= i_valid;
		end
	end

	// ****************************************
	// symmetry fold
	// ****************************************
	// pair k is tap k with tap 28-k
	always_comb begin
		for (int k = 0; k < `FIR_NUM_UNIQ; k++) begin
			o_pairs[k].near = taps_q[k];
			if (k == CENTER) begin
				o_pairs[k].far = '0;
			end else begin
				o_pairs[k].far = taps_q[`FIR_NUM_TAPS-1-k];
			end
		end
	end

	assign o_valid = valid_q;

endmodule

`default_nettype wire

/* hdl/symmetric_tap.sv */
// ****************************************
// one folded fir tap, pre-add of a mirrored pair then multiply
// by a constant coefficient, two enabled edges deep
// ****************************************
`timescale 1ns/1ps
`default_nettype none

`include "fir_params.svh"

module symmetric_tap #(
	parameter fir_pkg::fir_sample_t COEFF = '0
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_clk_ena,
	input  fir_pkg::fir_pair_t    i_pair,
	output fir_pkg::fir_product_t o_product
);

	fir_pkg::fir_sample_t                pre_sum_q;
	logic signed [2*`FIR_DATA_W-1:0]     full_product;
	logic signed [2*`FIR_DATA_W-1:0]     scaled_product;
	fir_pkg::fir_product_t               product_q;

	// full precision product, then normalize
	assign full_product   = pre_sum_q * COEFF;
	assign scaled_product = full_product >>> `FIR_SCALE;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pre_sum_q <= '0;
			product_q <= '0;
		end else if (i_clk_ena) begin
			// wraps to the sample width
			pre_sum_q <= i_pair.near + i_pair.far;
			product_q <= scaled_product[`FIR_DATA_W-1:0];
		end
	end

	assign o_product = product_q;

endmodule

`default_nettype wire

/* hdl/product_sum_tree.sv */
// ****************************************
// registered adder tree over the tap products, one level per edge
// also delays the valid bit so that o_valid marks o_data
// ****************************************
`timescale 1ns/1ps
`default_nettype none

`include "fir_params.svh"

module product_sum_tree (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_clk_ena,
	input  fir_pkg::fir_product_t i_products [`FIR_NUM_UNIQ],
	input  logic                  i_valid,
	output fir_pkg::fir_sample_t  o_data,
	output logic                  o_valid
);

	localparam int N            = `FIR_TREE_INPUTS;
	localparam int NODES        = 2 * N - 1;
	localparam int VALID_STAGES = `FIR_TAP_STAGES + `FIR_TREE_LEVELS;

	// leaves in 0..N-1, each level appended after the previous one,
	// root in the last slot
	wire fir_pkg::fir_sample_t tree_node [NODES];

	logic [VALID_STAGES-1:0] valid_q;

	// ****************************************
	// leaves
	// ****************************************
	for (genvar i = 0; i < N; i++) begin : g_leaf
		if (i < `FIR_NUM_UNIQ) begin : g_product
			assign tree_node[i] = i_products[i];
		end else begin : g_pad
			assign tree_node[i] = '0;
		end
	end

	// ****************************************
	// adder levels
	// ****************************************
	for (genvar lvl = 0; lvl < `FIR_TREE_LEVELS; lvl++) begin : g_level
		localparam int IN_BASE  = 2 * N - 2 * (N >> lvl);
		localparam int OUT_BASE = 2 * N - 2 * (N >> (lvl + 1));
		localparam int COUNT    = N >> (lvl + 1);

		fir_pkg::fir_sample_t sum_q [COUNT];

		// pairwise sums, wrapping at the sample width
		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				for (int j = 0; j < COUNT; j++) begin
					sum_q[j] <= '0;
				end
			end else if (i_clk_ena) begin
				for (int j = 0; j < COUNT; j++) begin
					sum_q[j] <= tree_node[IN_BASE+2*j] + tree_node[IN_BASE+2*j+1];
				end
			end
		end

		for (genvar j = 0; j < COUNT; j++) begin : g_out
			assign tree_node[OUT_BASE+j] = sum_q[j];
		end
	end

	// ****************************************
	// valid alignment
	// ****************************************
	// covers the tap stages and the tree levels
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= '0;
		end else if (i_clk_ena) begin
			valid_q <= {valid_q[VALID_STAGES-2:0], i_valid};
		end
	end

	assign o_data  = tree_node[NODES-1];
	assign o_valid = valid_q[VALID_STAGES-1];

endmodule

`default_nettype wire

/* hdl/fir_filter.sv */
// ****************************************
// top level of the symmetric 29-tap fir filter
// i_clk_ena low stalls every stage, y[n] appears after 7 enabled edges
// ****************************************
`timescale 1ns/1ps
`default_nettype none

`include "fir_params.svh"

module fir_filter (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_clk_ena,
	input  logic                 i_valid,
	input  fir_pkg::fir_sample_t i_data,
	output logic                 o_valid,
	output fir_pkg::fir_sample_t o_data
);

	wire fir_pkg::fir_pair_t    pairs [`FIR_NUM_UNIQ];
	wire fir_pkg::fir_product_t products [`FIR_NUM_UNIQ];
	logic                       pair_valid;

	// ****************************************
	// delay line and symmetry fold
	// ****************************************
	tap_delay_line u_tap_delay_line (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_data    (i_data),
		.o_pairs   (pairs),
		.o_valid   (pair_valid)
	);

	// ****************************************
	// pre-add and multiply, one tap per pair
	// ****************************************
	for (genvar k = 0; k < `FIR_NUM_UNIQ; k++) begin : g_tap
		symmetric_tap #(
			.COEFF (fir_pkg::FIR_COEFFS[k])
		) u_symmetric_tap (
			.clk       (clk),
			.reset     (reset),
			.i_clk_ena (i_clk_ena),
			.i_pair    (pairs[k]),
			.o_product (products[k])
		);
	end

	// ****************************************
	// adder tree and output
	// ****************************************
	// valid from the delay line runs alongside the taps inside the tree
	product_sum_tree u_product_sum_tree (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.i_valid    (pair_valid),
		.o_data     (o_data),
		.o_valid    (o_valid)
	);

endmodule

`default_nettype wire

/* testbench/tb_fir_filter.sv */
// ****************************************
// self-checking testbench of the symmetric fir filter
// replays testbench/fir_input_vectors.txt one line per clock and
// compares o_valid and o_data with the expected columns
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_fir_filter;

	localparam int RESET_CYCLES = 10;
	localparam int TIMEOUT_SLACK = 20;

	// one line of the vector file
	typedef struct packed {
		int   test;
		logic ena;
		logic valid;
		int   data;
		logic exp_valid;
		int   exp_data;
	} vector_t;

	logic                 clk;
	logic                 reset;
	logic                 i_clk_ena;
	logic                 i_valid;
	fir_pkg::fir_sample_t i_data;
	logic                 o_valid;
	fir_pkg::fir_sample_t o_data;

	vector_t vectors [$];
	int      errors;
	int      checks;
	int      cycles;
	int      cycle_limit;

	fir_filter u_fir_filter (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_data    (i_data),
		.o_valid   (o_valid),
		.o_data    (o_data)
	);

	// ****************************************
	// clock and watchdog
	// ****************************************
	initial begin
		clk = 1'b0;
	end

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: run passed %0d cycles without finishing", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	// ****************************************
	// helpers
	// ****************************************
	function automatic string test_name(input int id);
		case (id)
			0: return "reset";
			1: return "impulse";
			2: return "latency";
			3: return "stall";
			4: return "full_scale";
			default: return "unknown";
		endcase
	endfunction

	task automatic check_value(input string name, input int expected,
		input logic signed [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("CHECK FAILED %s expected %0d actual %0d at %0t",
				name, expected, actual, $time);
		end
	endtask

	// returns 0 when the file is missing or holds a bad line
	task automatic load_vectors(output bit ok);
		int      fd;
		int      n;
		int      line_no;
		int      col [6];
		string   line;
		vector_t vec;
		ok = 1'b1;
		line_no = 0;
		fd = $fopen("testbench/fir_input_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file testbench/fir_input_vectors.txt");
			ok = 1'b0;
		end else begin
			while ($fgets(line, fd) != 0) begin
				line_no++;
				if (line.len() > 0 && line.substr(0, 0) != "#") begin
					n = $sscanf(line, "%d %d %d %d %d %d",
						col[0], col[1], col[2], col[3], col[4], col[5]);
					if (n == 6) begin
						vec.test      = col[0];
						vec.ena       = col[1][0];
						vec.valid     = col[2][0];
						vec.data      = col[3];
						vec.exp_valid = col[4][0];
						vec.exp_data  = col[5];
						vectors.push_back(vec);
					end else if (n > 0) begin
						$display("vector file line %0d has %0d of 6 columns", line_no, n);
						ok = 1'b0;
					end
				end
			end
			$fclose(fd);
			if (vectors.size() == 0) begin
				$display("vector file holds no vectors");
				ok = 1'b0;
			end
		end
	endtask

	task automatic finish_run();
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	// ****************************************
	// main sequence
	// ****************************************
	initial begin : main
		bit                 file_ok;
		vector_t            vec;
		string              name;
		logic signed [31:0] got;
		errors = 0;
		checks = 0;
		cycles = 0;
		cycle_limit = 0;
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_data = '0;

		load_vectors(file_ok);
		if (!file_ok) begin
			errors++;
		end else begin
			// two extra cycles cover the reset release
			cycle_limit = vectors.size() + RESET_CYCLES + TIMEOUT_SLACK + 2;

			// outputs must stay cleared while reset is held
			for (int i = 0; i < RESET_CYCLES; i++) begin
				@(posedge clk);
				#38;
				got = o_data;
				check_value("reset valid", 0, o_valid);
				check_value("reset data", 0, got);
			end
			@(posedge clk);
			#2;
			reset = 1'b0;

			foreach (vectors[i]) begin
				vec = vectors[i];
				name = test_name(vec.test);
				@(posedge clk);
				#2;
				i_clk_ena = vec.ena;
				i_valid = vec.valid;
				i_data = fir_pkg::fir_sample_t'(vec.data);
				// sample just before the next rising edge
				#36;
				got = o_data;
				check_value({name, " valid"}, int'(vec.exp_valid), o_valid);
				check_value({name, " data"}, vec.exp_data, got);
			end
		end
		finish_run();
	end

endmodule

`default_nettype wire

/* testbench/fir_input_vectors.txt */
# columns: test ena valid data expected_valid expected_data
# test ids 1 impulse, 2 latency and burst, 3 stall, 4 full scale stream
1 1 1 131071 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 1 0 0 1 87
1 1 0 0 0 0
1 1 0 0 0 -97
1 1 0 0 0 -197
1 1 0 0 0 -294
1 1 0 0 0 -380
1 1 0 0 0 -447
1 1 0 0 0 -490
1 1 0 0 0 -504
1 1 0 0 0 -481
1 1 0 0 0 -420
1 1 0 0 0 -319
1 1 0 0 0 -178
1 1 0 0 0 0
1 1 0 0 0 211
1 1 0 0 0 0
1 1 0 0 0 -178
1 1 0 0 0 -319
1 1 0 0 0 -420
1 1 0 0 0 -481
1 1 0 0 0 -504
1 1 0 0 0 -490
2 1 1 131071 0 -447
2 1 1 -131072 0 -380
2 1 1 131071 0 -294
3 0 1 77777 0 -197
3 0 1 77777 0 -197
3 0 1 77777 0 -197
3 1 1 -131072 0 -197
3 1 1 131071 0 -97
3 1 0 0 0 0
3 1 0 0 0 87
2 1 0 0 1 87
2 1 0 0 1 -88
2 1 0 0 1 -10
2 1 0 0 1 -188
2 1 0 0 1 -107
4 1 0 0 0 -186
4 1 0 0 0 -261
4 1 0 0 0 -326
4 1 0 0 0 -375
4 1 0 0 0 -400
4 1 0 0 0 -400
4 1 0 0 0 -366
4 1 0 0 0 -302
4 1 0 0 0 -202
4 1 0 0 0 -68
4 1 0 0 0 -353
4 1 0 0 0 211
4 1 0 0 0 -353

/* sim.f */
+incdir+hdl
hdl/fir_pkg.sv
hdl/tap_delay_line.sv
hdl/symmetric_tap.sv
hdl/product_sum_tree.sv
hdl/fir_filter.sv
testbench/tb_fir_filter.sv

/* Bender.yml */
package:
  name: fir_filter

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fir_pkg.sv
      - hdl/tap_delay_line.sv
      - hdl/symmetric_tap.sv
      - hdl/product_sum_tree.sv
      - hdl/fir_filter.sv
  - target: simulation
    files:
      - testbench/tb_fir_filter.sv
